/* compile.f */
src/IsaPkg.sv
src/PipePkg.sv
src/HazardDetectionUnit.sv
src/StageControlPipe.sv
src/BranchCondition.sv
src/PipelineControl.sv
tb/PipelineControl_assertions.sv
tb/PipelineControlTb.sv

/* Makefile */
VERILATOR   ?= verilator
TOP         ?= PipelineControlTb
FILELIST    ?= compile.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
ERROR_LIMIT ?= 100
VFLAGS      ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "No pass line in $(LOG)"; exit 1; fi
	@echo "Run passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/PipelineControlTb.sv */
module PipelineControlTb
  import IsaPkg::*;
  import PipePkg::*;
;

  localparam int clkPeriod = 100;
  localparam int numTests  = 5;

  logic      clk;
  logic      reset;
  decodeCtlT decodeCtl;
  aluFlagsT  exFlags;
  logic      icacheBusy;
  logic      dcacheBusy;
  stallCtlT  stallCtl;
  flushCtlT  flushCtl;
  logic      branchTaken;
  stageCtlT  wbCtl;

  stageCtlT mIdEx;   // Reference ID/EX
  stageCtlT mExMem;  // Reference EX/MEM
  stageCtlT mWb;     // Reference MEM/WB
  aluFlagsT mFlags;  // Reference Z/N/V

  PipelineControl PipelineControl_i (
    .clk(clk), .reset(reset), .decodeCtl(decodeCtl), .exFlags(exFlags),
    .icacheBusy(icacheBusy), .dcacheBusy(dcacheBusy), .stallCtl(stallCtl),
    .flushCtl(flushCtl), .branchTaken(branchTaken), .wbCtl(wbCtl)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // Limit scales with the number of directed tests
  initial begin
    #((numTests * 40 + 20) * clkPeriod);
    $display("Timeout: the tests did not finish in the allowed time");
    $display("Simulation failed");
    $fatal(1, "Watchdog expired");
  end

  ////////////////////////////////////////////////////////////////////
  // Reporting and compare tasks
  ////////////////////////////////////////////////////////////////////

  task automatic failRun(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkStall(stallCtlT actual, stallCtlT expected, string name);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected));
    end
  endtask

  task automatic checkFlush(flushCtlT actual, flushCtlT expected, string name);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected));
    end
  endtask

  task automatic checkTaken(logic actual, logic expected, string name);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch at %0t: %s is %b, expected %b", $time, name, actual, expected));
    end
  endtask

  task automatic checkWb(stageCtlT actual, stageCtlT expected, string name);
    if (actual !== expected) begin
      failRun($sformatf("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected));
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Instruction builders and reference rules
  ////////////////////////////////////////////////////////////////////

  function automatic decodeCtlT aluOp(regIdT dest, regIdT src, logic setFlags);
    decodeCtlT d;
    d = '0;
    d.destReg  = dest;
    d.srcReg1  = src;
    d.srcReg2  = src;
    d.regWrite = 1'b1;
    d.zEn      = setFlags;  // Compare style op when set
    d.nvEn     = setFlags;
    return d;
  endfunction

  function automatic decodeCtlT memOp(regIdT reg2, regIdT base, logic store);
    decodeCtlT d;
    d = '0;
    d.srcReg1   = base;
    d.memEnable = 1'b1;
    d.memWrite  = store;
    d.regWrite  = !store;
    if (store) begin
      d.srcReg2 = reg2;  // Store data
    end else begin
      d.destReg = reg2;  // Load target
    end
    return d;
  endfunction

  function automatic decodeCtlT branchOp(int cond, logic br, regIdT target);
    decodeCtlT d;
    d = '0;
    d.branch  = 1'b1;
    d.br      = br;
    d.srcReg1 = target;
    d.cond    = branchCondT'(cond);
    return d;
  endfunction

  function automatic stageCtlT makeStage(decodeCtlT d);
    stageCtlT s;
    s = '{destReg: d.destReg, regWrite: d.regWrite, memEnable: d.memEnable,
          memWrite: d.memWrite, zEn: d.zEn, nvEn: d.nvEn};
    return s;
  endfunction

  // Branch condition table
  function automatic logic condHolds(int cond, aluFlagsT f);
    case (cond)
      0: return !f.z;
      1: return f.z;
      2: return !f.z && !f.n;
      3: return f.n;
      4: return f.z || !f.n;
      5: return f.z || f.n;
      6: return f.v;
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic refHazard(decodeCtlT d);
    logic loadUse;
    logic flagWait;
    logic brWait;
    loadUse = mIdEx.memEnable && !mIdEx.memWrite && (mIdEx.destReg != 4'h0) &&
        ((mIdEx.destReg == d.srcReg1) || ((mIdEx.destReg == d.srcReg2) && !d.memWrite));
    flagWait = d.branch && (mIdEx.zEn || mIdEx.nvEn);
    brWait = d.branch && d.br && ((mIdEx.zEn || mIdEx.nvEn) ||
        (mIdEx.regWrite && (mIdEx.destReg != 4'h0) && (mIdEx.destReg == d.srcReg1)) ||
        (mExMem.regWrite && (mExMem.destReg != 4'h0) && (mExMem.destReg == d.srcReg1)));
    return loadUse || flagWait || brWait;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Drive and clock step
  ////////////////////////////////////////////////////////////////////

  // Called at the falling edge, then waits for outputs to settle
  task automatic drive(decodeCtlT d, logic ib, logic db, aluFlagsT f);
    decodeCtl  = d;
    icacheBusy = ib;
    dcacheBusy = db;
    exFlags    = f;
    #10;
  endtask

  // Checks against the reference, takes one edge, compares wbCtl
  task automatic advance();
    stallCtlT  es;
    flushCtlT  ef;
    logic      et;
    decodeCtlT d;
    d = decodeCtl;
    et = d.branch && condHolds(int'(d.cond), mFlags);
    es.exMemStall = dcacheBusy;
    es.idExStall  = dcacheBusy;
    es.ifIdStall  = dcacheBusy || refHazard(d);
    es.pcStall    = icacheBusy || es.ifIdStall;
    ef.memFlush   = dcacheBusy;
    ef.idFlush    = refHazard(d);
    ef.ifFlush    = icacheBusy || (et && !es.ifIdStall);
    checkStall(stallCtl, es, "stallCtl");
    checkFlush(flushCtl, ef, "flushCtl");
    checkTaken(branchTaken, et, "branchTaken");
    @(posedge clk);
    if ((mIdEx.zEn || mIdEx.nvEn) && !es.idExStall) begin
      if (mIdEx.zEn) begin
        mFlags.z = exFlags.z;
      end
      if (mIdEx.nvEn) begin
        mFlags.n = exFlags.n;
        mFlags.v = exFlags.v;
      end
    end
    if (ef.memFlush) begin
      mWb = '0;
    end else begin
      mWb = mExMem;
    end
    if (!es.exMemStall) begin
      mExMem = mIdEx;
    end
    if (ef.idFlush) begin
      mIdEx = '0;
    end else if (!es.idExStall) begin
      mIdEx = makeStage(d);
    end
    @(negedge clk);
    checkWb(wbCtl, mWb, "wbCtl");
    if (PipelineControl_i.PipelineControl_assertions_i.failCount != 0) begin
      failRun("A bound assertion on the stall and flush lines failed");
    end
  endtask

  task automatic drain();
    repeat (3) begin
      drive('0, 1'b0, 1'b0, '0);
      advance();
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////

  task automatic testReset();
    drive('0, 1'b0, 1'b0, '0);
    checkStall(stallCtl, '0, "stallCtl after reset");
    checkFlush(flushCtl, '0, "flushCtl after reset");
    checkTaken(branchTaken, 1'b0, "branchTaken after reset");
    checkWb(wbCtl, '0, "wbCtl after reset");
    advance();
  endtask

  task automatic testLoadUse();
    regIdT r;
    regIdT other;
    r = regIdT'(1 + $urandom % 15);
    other = regIdT'((r % 15) + 1);  // Never equal to r
    drive(memOp(r, other, 1'b0), 1'b0, 1'b0, '0);
    advance();
    drive(aluOp(other, r, 1'b0), 1'b0, 1'b0, '0);
    checkStall(stallCtl, 4'b1100, "stallCtl on load-use");
    checkFlush(flushCtl, 3'b010, "flushCtl on load-use");
    advance();
    checkStall(stallCtl, '0, "stallCtl behind bubble");  // Reader retried
    advance();
    drive('0, 1'b0, 1'b0, '0);
    advance();
    checkWb(wbCtl, '0, "wbCtl bubble");
    // Store data from the load is forwarded
    drive(memOp(r, other, 1'b0), 1'b0, 1'b0, '0);
    advance();
    drive(memOp(r, other, 1'b1), 1'b0, 1'b0, '0);
    checkStall(stallCtl, '0, "stallCtl on store data");
    advance();
    drive(memOp(4'h0, other, 1'b0), 1'b0, 1'b0, '0);
    advance();
    drive(aluOp(other, 4'h0, 1'b0), 1'b0, 1'b0, '0);
    checkStall(stallCtl, '0, "stallCtl on r0 load");
    advance();
    drain();
  endtask

  task automatic testBranchHazards();
    regIdT r;
    r = regIdT'(1 + $urandom % 15);
    drive(aluOp(r, 4'h0, 1'b1), 1'b0, 1'b0, '0);
    advance();
    drive(branchOp(7, 1'b0, 4'h0), 1'b0, 1'b0, '0);
    checkStall(stallCtl, 4'b1100, "stallCtl on B after flags");
    checkFlush(flushCtl, 3'b010, "flushCtl on B after flags");
    advance();
    checkFlush(flushCtl, 3'b100, "flushCtl on released B");
    advance();
    drive(aluOp(r, 4'h0, 1'b0), 1'b0, 1'b0, '0);
    advance();
    drive(branchOp(7, 1'b1, r), 1'b0, 1'b0, '0);
    checkStall(stallCtl, 4'b1100, "stallCtl on BR vs ID/EX");
    advance();
    checkStall(stallCtl, 4'b1100, "stallCtl on BR vs EX/MEM");
    advance();
    checkStall(stallCtl, '0, "stallCtl on released BR");
    advance();
    drive(aluOp(regIdT'((r % 15) + 1), 4'h0, 1'b0), 1'b0, 1'b0, '0);
    advance();
    drive(branchOp(7, 1'b1, r), 1'b0, 1'b0, '0);
    checkStall(stallCtl, '0, "stallCtl on independent BR");
    checkFlush(flushCtl, 3'b100, "flushCtl on independent BR");
    advance();
    drain();
  endtask

  task automatic testCachePressure();
    decodeCtlT older;  // Waits in EX/MEM
    decodeCtlT inst;   // Waits in ID/EX
    int        n;
    n = 1 + $urandom % 4;
    older = aluOp(regIdT'(1 + $urandom % 15), 4'h0, 1'b0);
    inst = memOp(regIdT'(1 + $urandom % 15), 4'h0, 1'b1);
    drive(older, 1'b0, 1'b0, '0);
    advance();
    drive(inst, 1'b0, 1'b0, '0);
    advance();
    repeat (n) begin
      drive('0, 1'b0, 1'b1, '0);
      checkStall(stallCtl, 4'b1111, "stallCtl on dcacheBusy");
      checkFlush(flushCtl, 3'b001, "flushCtl on dcacheBusy");
      advance();
      checkWb(wbCtl, '0, "wbCtl during dcacheBusy");
    end
    drive('0, 1'b0, 1'b0, '0);
    advance();
    checkWb(wbCtl, makeStage(older), "wbCtl released instruction");
    advance();
    checkWb(wbCtl, makeStage(inst), "wbCtl held instruction");
    drive('0, 1'b1, 1'b0, '0);
    checkStall(stallCtl, 4'b1000, "stallCtl on icacheBusy");
    checkFlush(flushCtl, 3'b100, "flushCtl on icacheBusy");
    advance();
    drain();
  endtask

  task automatic testBranchEval();
    aluFlagsT f;
    logic     taken;
    repeat (2) begin
      f = aluFlagsT'($urandom % 8);
      drive(aluOp(4'h1, 4'h0, 1'b1), 1'b0, 1'b0, '0);
      advance();
      drive('0, 1'b0, 1'b0, f);  // Flags of the EX instruction
      advance();
      for (int c = 0; c < 8; c++) begin
        taken = condHolds(c, f);
        drive(branchOp(c, 1'b0, 4'h0), 1'b0, 1'b0, '0);
        checkTaken(branchTaken, taken, "branchTaken");
        checkFlush(flushCtl, {taken, 2'b00}, "flushCtl on branch");
        advance();
        drive(branchOp(c, 1'b0, 4'h0), 1'b0, 1'b1, '0);
        checkTaken(branchTaken, taken, "branchTaken held");
        checkFlush(flushCtl, 3'b001, "flushCtl on held branch");
        advance();
      end
    end
    drain();
  endtask

  initial begin
    void'($urandom(1));
    reset      = 1'b1;
    decodeCtl  = '0;
    exFlags    = '0;
    icacheBusy = 1'b0;
    dcacheBusy = 1'b0;
    mIdEx      = '0;
    mExMem     = '0;
    mWb        = '0;
    mFlags     = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    testReset();
    testLoadUse();
    testBranchHazards();
    testCachePressure();
    testBranchEval();
    if (PipelineControl_i.PipelineControl_assertions_i.failCount == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "Bound assertions failed");
    end
  end

endmodule

/* tb/PipelineControl_assertions.sv */
module PipelineControl_assertions
  import PipePkg::*;
(
  input logic     clk,
  input logic     reset,
  input stallCtlT stallCtl,
  input flushCtlT flushCtl
);

  int failCount = 0;  // Failed assertions so far

  //////////////////////////////////////////////////////////////////////
  // Stall and flush consistency
  //////////////////////////////////////////////////////////////////////

  // PC never advances past a held IF/ID
  pcFollowsIfId: assert property (@(posedge clk) disable iff (reset)
      stallCtl.ifIdStall |-> stallCtl.pcStall)
    else begin
      $error("pcStall low while ifIdStall high");
      failCount++;
    end

  idExWithExMem: assert property (@(posedge clk) disable iff (reset)
      stallCtl.idExStall == stallCtl.exMemStall)
    else begin
      $error("idExStall differs from exMemStall");
      failCount++;
    end

  // A bubble into EX only when ID is held
  idFlushHoldsIfId: assert property (@(posedge clk) disable iff (reset)
      flushCtl.idFlush |-> stallCtl.ifIdStall)
    else begin
      $error("idFlush without ifIdStall");
      failCount++;
    end

  memFlushWithExMem: assert property (@(posedge clk) disable iff (reset)
      flushCtl.memFlush == stallCtl.exMemStall)
    else begin
      $error("memFlush differs from exMemStall");
      failCount++;
    end

endmodule

bind PipelineControl PipelineControl_assertions PipelineControl_assertions_i (
  .clk(clk), .reset(reset), .stallCtl(stallCtl), .flushCtl(flushCtl)
);

/* src/PipelineControl.sv */
module PipelineControl
  import IsaPkg::*;
  import PipePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  decodeCtlT decodeCtl,    // From the decoder
  input  aluFlagsT  exFlags,      // From the ALU
  input  logic      icacheBusy,
  input  logic      dcacheBusy,
  output stallCtlT  stallCtl,     // To the pipeline registers and PC
  output flushCtlT  flushCtl,
  output logic      branchTaken,  // PC redirect request
  output stageCtlT  wbCtl         // Write-back control
);

  stageCtlT idExCtl;
  stageCtlT exMemCtl;

  //////////////////////////////////////////////////////////////////////
  // Hazards and back-pressure
  //////////////////////////////////////////////////////////////////////

  HazardDetectionUnit HazardDetectionUnit_i (
    .decodeCtl   (decodeCtl),
    .idExCtl     (idExCtl),
    .exMemCtl    (exMemCtl),
    .branchTaken (branchTaken),
    .icacheBusy  (icacheBusy),
    .dcacheBusy  (dcacheBusy),
    .stallCtl    (stallCtl),
    .flushCtl    (flushCtl)
  );

  // ID/EX, EX/MEM and MEM/WB control
  StageControlPipe StageControlPipe_i (
    .clk       (clk),
    .reset     (reset),
    .decodeCtl (decodeCtl),
    .stallCtl  (stallCtl),
    .flushCtl  (flushCtl),
    .idExCtl   (idExCtl),
    .exMemCtl  (exMemCtl),
    .wbCtl     (wbCtl)
  );

  // Flags and predict-not-taken resolution
  BranchCondition BranchCondition_i (
    .clk         (clk),
    .reset       (reset),
    .decodeCtl   (decodeCtl),
    .idExCtl     (idExCtl),
    .idExStall   (stallCtl.idExStall),
    .exFlags     (exFlags),
    .branchTaken (branchTaken)
  );

endmodule

/* src/BranchCondition.sv */
module BranchCondition
  import IsaPkg::*;
  import PipePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  decodeCtlT decodeCtl,    // Branch in ID
  input  stageCtlT  idExCtl,      // Flag enables of the EX instruction
  input  logic      idExStall,    // EX instruction held in place
  input  aluFlagsT  exFlags,      // ALU flags of the EX instruction
  output logic      branchTaken
);

  aluFlagsT flagQ;    // Z/N/V register
  logic     condMet;

  //////////////////////////////////////////////////////////////////////
  // Flag register
  //////////////////////////////////////////////////////////////////////

  // Load once as the EX instruction moves on
  always_ff @(posedge clk) begin
    if (reset) begin
      flagQ <= '0;
    end else if (setsFlags(idExCtl) && !idExStall) begin
      if (idExCtl.zEn) begin
        flagQ.z <= exFlags.z;
      end
      if (idExCtl.nvEn) begin    // N and V always go together
        flagQ.n <= exFlags.n;
        flagQ.v <= exFlags.v;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Condition evaluation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (decodeCtl.cond)
      condNe:     condMet = !flagQ.z;
      condEq:     condMet = flagQ.z;
      condGt:     condMet = !flagQ.z && !flagQ.n;
      condLt:     condMet = flagQ.n;
      condGe:     condMet = flagQ.z || !flagQ.n;
      condLe:     condMet = flagQ.z || flagQ.n;
      condOvf:    condMet = flagQ.v;
      condUncond: condMet = 1'b1;
    endcase
  end

  // Stall checks are left to the hazard unit
  assign branchTaken = decodeCtl.branch && condMet;

endmodule

/* src/StageControlPipe.sv */
module StageControlPipe
  import PipePkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  decodeCtlT decodeCtl,  // Instruction in ID
  input  stallCtlT  stallCtl,
  input  flushCtlT  flushCtl,
  output stageCtlT  idExCtl,    // ID/EX control register
  output stageCtlT  exMemCtl,   // EX/MEM control register
  output stageCtlT  wbCtl       // MEM/WB control register
);

  stageCtlT idExNext;
  stageCtlT exMemNext;
  stageCtlT wbNext;

  // Keep only what travels past ID
  function automatic stageCtlT toStageCtl(decodeCtlT d);
    stageCtlT s;
    s.destReg   = d.destReg;
    s.regWrite  = d.regWrite;
    s.memEnable = d.memEnable;
    s.memWrite  = d.memWrite;
    s.zEn       = d.zEn;
    s.nvEn      = d.nvEn;
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  // Flush wins over hold so a hazard bubble always enters EX
  always_comb begin
    idExNext = idExCtl;
    if (flushCtl.idFlush) begin
      idExNext = stageNop;
    end else if (!stallCtl.idExStall) begin
      idExNext = toStageCtl(decodeCtl);
    end
  end

  always_comb begin
    exMemNext = exMemCtl;  // Held while the data cache is busy
    if (!stallCtl.exMemStall) begin
      exMemNext = idExCtl;
    end
  end

  // No hold on MEM/WB so WB sees a NOP each busy cycle
  always_comb begin
    if (flushCtl.memFlush) begin
      wbNext = stageNop;
    end else begin
      wbNext = exMemCtl;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stage registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      idExCtl <= stageNop;
    end else begin
      idExCtl <= idExNext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      exMemCtl <= stageNop;
    end else begin
      exMemCtl <= exMemNext;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wbCtl <= stageNop;
    end else begin
      wbCtl <= wbNext;
    end
  end

endmodule

/* src/HazardDetectionUnit.sv */
module HazardDetectionUnit
  import IsaPkg::*;
  import PipePkg::*;
(
  input  decodeCtlT decodeCtl,    // Instruction in ID
  input  stageCtlT  idExCtl,      // Instruction in EX
  input  stageCtlT  exMemCtl,     // Instruction in MEM
  input  logic      branchTaken,  // Branch in ID meets its condition
  input  logic      icacheBusy,   // Fetch miss pending
  input  logic      dcacheBusy,   // Data access pending
  output stallCtlT  stallCtl,
  output flushCtlT  flushCtl
);

  logic idExLoad;       // LW sitting in EX
  logic idExFlags;      // EX instruction will write flags
  logic loadUseHazard;
  logic bHazard;
  logic brInst;
  logic brExHazard;     // Rs produced by the EX instruction
  logic brMemHazard;    // Rs produced by the MEM instruction
  logic brHazard;
  logic anyHazard;

  //////////////////////////////////////////////////////////////////////
  // Load-to-use
  //////////////////////////////////////////////////////////////////////

  assign idExLoad = isLoad(idExCtl);

  // Rt of a store is covered by MEM-to-MEM forwarding
  assign loadUseHazard = idExLoad && (idExCtl.destReg != regZero) &&
      ((idExCtl.destReg == decodeCtl.srcReg1) ||
       ((idExCtl.destReg == decodeCtl.srcReg2) && !decodeCtl.memWrite));

  //////////////////////////////////////////////////////////////////////
  // Branches
  //////////////////////////////////////////////////////////////////////

  assign idExFlags = setsFlags(idExCtl);

  // Flags not settled until the EX instruction leaves
  assign bHazard = decodeCtl.branch && idExFlags;

  assign brInst = decodeCtl.branch && decodeCtl.br;

  assign brExHazard = idExCtl.regWrite && (idExCtl.destReg != regZero) &&
      (idExCtl.destReg == decodeCtl.srcReg1);

  assign brMemHazard = exMemCtl.regWrite && (exMemCtl.destReg != regZero) &&
      (exMemCtl.destReg == decodeCtl.srcReg1);

  // BR reads its target in ID so both older writers block it
  assign brHazard = brInst && (idExFlags || brExHazard || brMemHazard);

  assign anyHazard = loadUseHazard || bHazard || brHazard;

  //////////////////////////////////////////////////////////////////////
  // Stall and flush
  //////////////////////////////////////////////////////////////////////

  // Data cache freezes everything from EX/MEM backwards
  assign stallCtl.exMemStall = dcacheBusy;
  assign stallCtl.idExStall  = dcacheBusy;
  assign stallCtl.ifIdStall  = dcacheBusy || anyHazard;
  assign stallCtl.pcStall    = icacheBusy || dcacheBusy || anyHazard;

  // Bubble into WB while the memory stage waits
  assign flushCtl.memFlush = dcacheBusy;

  // Bubble into EX behind a held ID instruction
  assign flushCtl.idFlush = anyHazard;

  // Kill the fetched word on a miss or on a redirect that is acted on
  assign flushCtl.ifFlush = icacheBusy ||
      (branchTaken && decodeCtl.branch && !dcacheBusy && !anyHazard);

endmodule

/* src/PipePkg.sv */
package PipePkg;
  import IsaPkg::*;

  //////////////////////////////////////////////////////////////////////
  // Control words
  //////////////////////////////////////////////////////////////////////

  // Decoder output for the instruction in ID
  typedef struct packed {
    regIdT      srcReg1;    // Rs and the BR target register
    regIdT      srcReg2;    // Rt
    regIdT      destReg;    // Rd
    logic       regWrite;   // Writes the register file in WB
    logic       memEnable;  // Data memory access
    logic       memWrite;   // Store when set with memEnable
    logic       zEn;        // Updates Z
    logic       nvEn;       // Updates N and V
    logic       branch;     // Any branch
    logic       br;         // Register target form
    branchCondT cond;
  } decodeCtlT;

  // What each stage register keeps past ID
  typedef struct packed {
    regIdT destReg;
    logic  regWrite;
    logic  memEnable;
    logic  memWrite;
    logic  zEn;
    logic  nvEn;
  } stageCtlT;

  localparam stageCtlT stageNop = '0;  // Bubble

  //////////////////////////////////////////////////////////////////////
  // Stall and flush lines to the datapath
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic pcStall;
    logic ifIdStall;
    logic idExStall;
    logic exMemStall;
  } stallCtlT;

  typedef struct packed {
    logic ifFlush;   // IF/ID instruction word to NOP
    logic idFlush;   // ID/EX to NOP
    logic memFlush;  // MEM/WB to NOP
  } flushCtlT;

  // Memory read without write
  function automatic logic isLoad(stageCtlT s);
    return s.memEnable && !s.memWrite;
  endfunction

  function automatic logic setsFlags(stageCtlT s);
    return s.zEn || s.nvEn;
  endfunction

endpackage

/* src/IsaPkg.sv */
package IsaPkg;

  //////////////////////////////////////////////////////////////////////
  // Register file
  //////////////////////////////////////////////////////////////////////

  // Sixteen general purpose registers
  typedef logic [3:0] regIdT;

  // R0 is hardwired to zero so it never forms a hazard
  localparam regIdT regZero = 4'h0;

  //////////////////////////////////////////////////////////////////////
  // Branch conditions
  //////////////////////////////////////////////////////////////////////

  // Encoding of the 3-bit cond field in B and BR instructions
  typedef enum logic [2:0] {
    condNe     = 3'b000,  // Z clear
    condEq     = 3'b001,  // Z set
    condGt     = 3'b010,  // Z and N both clear
    condLt     = 3'b011,  // N set
    condGe     = 3'b100,  // Z set or N clear
    condLe     = 3'b101,  // Z or N set
    condOvf    = 3'b110,  // V set
    condUncond = 3'b111   // Always taken
  } branchCondT;

  //////////////////////////////////////////////////////////////////////
  // ALU flags
  //////////////////////////////////////////////////////////////////////

  // Same bit order as the flag register
  typedef struct packed {
    logic z;  // Result was zero
    logic n;  // Result was negative
    logic v;  // Signed overflow
  } aluFlagsT;

endpackage
